//--- mvu_defs.svh
// ==================================================
// Build-time sizes of the bit-serial MVU engine.
// Include this header wherever a width or depth
// is needed. The packages build their types on it.
// ==================================================
`ifndef MVU_DEFS_SVH
`define MVU_DEFS_SVH

`define MVU_N           8   // Lanes per bit plane
`define MVU_BPREC       3   // Precision field, holds 1 to MVU_MAXPREC
`define MVU_MAXPREC     4   // Largest allowed precision
`define MVU_BWADDR      6   // Weight bank address
`define MVU_BDADDR      4   // Data bank address
`define MVU_BROWS       4   // Row count minus one
`define MVU_BACC        16  // Accumulator and result word
`define MVU_BSHIFT      3   // Sum of two bit positions

// Result buffer sizing
`define MVU_FIFO_DEPTH  4
`define MVU_PIPE_SLACK  3   // Bank, vvp and shacc stages in flight

`endif

//--- mvu_data_pkg.sv
// ==================================================
// Data path types of the MVU engine: bit planes,
// bank addresses, accumulator words, memory write
// ports and the tag that follows each walker step.
// ==================================================
`default_nettype none
`include "mvu_defs.svh"

package mvu_data_pkg;

    typedef logic [`MVU_N-1:0]             mvu_plane_t;  // One bit of every lane
    typedef logic [`MVU_BWADDR-1:0]        mvu_waddr_t;
    typedef logic [`MVU_BDADDR-1:0]        mvu_daddr_t;
    typedef logic signed [`MVU_BACC-1:0]   mvu_acc_t;
    typedef logic [`MVU_BSHIFT-1:0]        mvu_shift_t;

    typedef struct packed {
        logic       en;
        mvu_waddr_t addr;
        mvu_plane_t word;
    } mvu_wwr_t;

    typedef struct packed {
        logic       en;
        mvu_daddr_t addr;
        mvu_plane_t word;
    } mvu_dwr_t;

    // Travels with each step down the pipeline
    typedef struct packed {
        logic       valid;
        logic       neg;    // Exactly one operand on a signed MSB
        mvu_shift_t shift;
        logic       first;
        logic       last;
    } mvu_tag_t;

endpackage

`default_nettype wire

//--- mvu_cfg_pkg.sv
// ==================================================
// Job control types of the MVU engine: the job
// descriptor taken on the config channel and the
// states of the job controller.
// ==================================================
`default_nettype none
`include "mvu_defs.svh"

package mvu_cfg_pkg;

    typedef logic [`MVU_BPREC-1:0] mvu_prec_t;   // Actual precision, 1 and up
    typedef logic [`MVU_BROWS-1:0] mvu_rows_t;   // Row count minus one

    typedef struct packed {
        mvu_prec_t               iprec;
        mvu_prec_t               wprec;
        logic                    i_signed;
        logic                    w_signed;
        mvu_data_pkg::mvu_daddr_t ibase;
        mvu_data_pkg::mvu_waddr_t wbase;
        mvu_rows_t               rows_m1;
    } mvu_job_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,     // Walker stepping
        ST_DRAIN    // Waiting for the last results to leave
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- mvu_job_ctrl.sv
// ==================================================
// Job controller. Takes a descriptor on the config
// handshake, holds it for the walker and ends the
// job once every row result has left the engine.
// ==================================================
`timescale 1ns/1ps
`default_nettype none
`include "mvu_defs.svh"

module mvu_job_ctrl (
    input  wire                        mvu_ext,
    input  wire                        rst_n,
    input  wire                        cfg_valid,
    input  wire mvu_cfg_pkg::mvu_job_t cfg_job,
    input  wire                        agu_last,
    input  wire                        out_valid,
    input  wire                        out_ready,
    input  wire                        irq_clr,
    output logic                       cfg_ready,
    output mvu_cfg_pkg::mvu_job_t      job,
    output logic                       run,
    output logic                       busy,
    output logic                       done,
    output logic                       irq
);
    import mvu_cfg_pkg::*;

    ctrl_state_e state;
    mvu_rows_t   rcnt;       // Results accepted in this job
    logic        accept;
    logic        out_hs;
    logic        final_hs;

    assign cfg_ready = (state == ST_IDLE);
    assign run       = (state == ST_RUN);
    assign busy      = (state != ST_IDLE);
    assign accept    = cfg_valid && cfg_ready;
    assign out_hs    = busy && out_valid && out_ready;
    assign final_hs  = out_hs && (rcnt == job.rows_m1);

    always_ff @(posedge mvu_ext) begin
        if (accept) begin
            job <= cfg_job;
        end
    end

    always_ff @(posedge mvu_ext or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            rcnt  <= '0;
            done  <= 1'b0;
            irq   <= 1'b0;
        end else begin
            done <= final_hs;
            irq  <= final_hs || (irq && !irq_clr);   // Sticky until cleared
            if (accept) begin
                rcnt <= '0;
            end else if (out_hs) begin
                rcnt <= rcnt + 1'b1;
            end
            case (state)
                ST_IDLE:  if (accept) state <= ST_RUN;
                ST_RUN:   if (agu_last) state <= ST_DRAIN;
                ST_DRAIN: if (final_hs) state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // Descriptor must not move while it waits for the engine
    a_cfg_hold: assert property (@(posedge mvu_ext) disable iff (!rst_n)
        (cfg_valid && !cfg_ready) |=> (!cfg_valid || $stable(cfg_job)));

    a_prec_range: assert property (@(posedge mvu_ext) disable iff (!rst_n)
        accept |-> (cfg_job.iprec inside {[1:`MVU_MAXPREC]}) &&
                   (cfg_job.wprec inside {[1:`MVU_MAXPREC]}));

endmodule

`default_nettype wire

//--- mvu_bank.sv
// ==================================================
// Bit-plane memory with one write port and one
// registered read port. Serves as the weight bank
// and as the input-data bank.
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module mvu_bank #(
    parameter int BADDR = 4
) (
    input  wire                           mvu_ext,
    input  wire                           wr_en,
    input  wire [BADDR-1:0]               wr_addr,
    input  wire mvu_data_pkg::mvu_plane_t wr_word,
    input  wire [BADDR-1:0]               rd_addr,
    output mvu_data_pkg::mvu_plane_t      rd_word
);
    import mvu_data_pkg::*;

    mvu_plane_t mem [2**BADDR];

    always_ff @(posedge mvu_ext) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
        rd_word <= mem[rd_addr];   // One cycle read latency
    end

endmodule

`default_nettype wire

//--- mvu_agu.sv
// ==================================================
// Address walker. Steps through rows, then input
// bits, then weight bits, both from the MSB down,
// and tags every step for the pipeline behind it.
// Holds its position while the FIFO lacks room.
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module mvu_agu (
    input  wire                          mvu_ext,
    input  wire                          rst_n,
    input  wire mvu_cfg_pkg::mvu_job_t   job,
    input  wire                          run,
    input  wire                          room,
    output mvu_data_pkg::mvu_waddr_t     waddr,
    output mvu_data_pkg::mvu_daddr_t     daddr,
    output mvu_data_pkg::mvu_tag_t       tag,
    output logic                         agu_last
);
    import mvu_data_pkg::*;
    import mvu_cfg_pkg::*;

    mvu_prec_t  icnt;        // Input bits done in this row
    mvu_prec_t  wcnt;        // Weight bits done for this input bit
    mvu_rows_t  row;
    mvu_waddr_t wrow_base;   // row * wprec
    mvu_prec_t  ipos;
    mvu_prec_t  wpos;
    logic       step;
    logic       i_end;
    logic       w_end;

    assign step  = run && room;
    assign ipos  = job.iprec - 1'b1 - icnt;
    assign wpos  = job.wprec - 1'b1 - wcnt;
    assign i_end = (icnt == job.iprec - 1'b1);
    assign w_end = (wcnt == job.wprec - 1'b1);

    assign daddr = job.ibase + mvu_daddr_t'(ipos);
    assign waddr = job.wbase + wrow_base + mvu_waddr_t'(wpos);

    assign tag.valid = step;
    assign tag.neg   = (job.i_signed && icnt == '0) ^ (job.w_signed && wcnt == '0);
    assign tag.shift = mvu_shift_t'(ipos + wpos);
    assign tag.first = (icnt == '0) && (wcnt == '0);
    assign tag.last  = i_end && w_end;
    assign agu_last  = step && i_end && w_end && (row == job.rows_m1);

    always_ff @(posedge mvu_ext or negedge rst_n) begin
        if (!rst_n) begin
            icnt      <= '0;
            wcnt      <= '0;
            row       <= '0;
            wrow_base <= '0;
        end else if (!run) begin   // Park at the start of the next job
            icnt      <= '0;
            wcnt      <= '0;
            row       <= '0;
            wrow_base <= '0;
        end else if (step) begin
            if (!w_end) begin
                wcnt <= wcnt + 1'b1;
            end else begin
                wcnt <= '0;
                if (!i_end) begin
                    icnt <= icnt + 1'b1;
                end else begin
                    icnt      <= '0;
                    row       <= row + 1'b1;
                    wrow_base <= wrow_base + mvu_waddr_t'(job.wprec);
                end
            end
        end
    end

    // Every step lies inside the job's precisions and rows
    a_step_in_job: assert property (@(posedge mvu_ext) disable iff (!rst_n)
        tag.valid |-> (icnt < job.iprec) && (wcnt < job.wprec) && (row <= job.rows_m1));

endmodule

`default_nettype wire

//--- mvu_vvp.sv
// ==================================================
// Vector-product stage for one bit pair. The tag
// waits a cycle to meet the bank output; then the
// popcount of the lane-wise AND is shifted into
// place and negated on a signed MSB term.
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module mvu_vvp (
    input  wire                           mvu_ext,
    input  wire                           rst_n,
    input  wire mvu_data_pkg::mvu_plane_t wplane,
    input  wire mvu_data_pkg::mvu_plane_t dplane,
    input  wire mvu_data_pkg::mvu_tag_t   tag_in,
    output mvu_data_pkg::mvu_acc_t        term,
    output mvu_data_pkg::mvu_tag_t        tag_out
);
    import mvu_data_pkg::*;

    mvu_tag_t   tag_q;   // Lined up with the bank read data
    mvu_plane_t hits;
    mvu_acc_t   ones;
    mvu_acc_t   mag;

    assign hits = wplane & dplane;

    always_comb begin
        ones = '0;
        for (int k = 0; k < $bits(mvu_plane_t); k++) begin
            ones = ones + mvu_acc_t'(hits[k]);
        end
    end

    assign mag = ones <<< tag_q.shift;

    always_ff @(posedge mvu_ext or negedge rst_n) begin
        if (!rst_n) begin
            tag_q   <= '0;
            tag_out <= '0;
        end else begin
            tag_q   <= tag_in;
            tag_out <= tag_q;
        end
    end

    always_ff @(posedge mvu_ext) begin
        term <= tag_q.neg ? -mag : mag;
    end

endmodule

`default_nettype wire

//--- mvu_shacc.sv
// ==================================================
// Shift-accumulator. Sums the shifted bit-pair
// terms of one row and pushes the row result one
// cycle after the term tagged last.
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module mvu_shacc (
    input  wire                         mvu_ext,
    input  wire                         rst_n,
    input  wire mvu_data_pkg::mvu_acc_t term,
    input  wire mvu_data_pkg::mvu_tag_t tag,
    output logic                        push,
    output mvu_data_pkg::mvu_acc_t      result
);
    import mvu_data_pkg::*;

    mvu_acc_t acc;
    mvu_acc_t sum;

    assign sum = tag.first ? term : acc + term;   // First term starts a new row

    always_ff @(posedge mvu_ext) begin
        if (tag.valid) begin
            acc <= sum;
        end
        if (tag.valid && tag.last) begin
            result <= sum;
        end
    end

    always_ff @(posedge mvu_ext or negedge rst_n) begin
        if (!rst_n) begin
            push <= 1'b0;
        end else begin
            push <= tag.valid && tag.last;
        end
    end

    // Rows from the walker never overlap
    a_row_frame: assert property (@(posedge mvu_ext) disable iff (!rst_n)
        (tag.valid && tag.first && !tag.last) |=>
            (!(tag.valid && tag.first) until_with (tag.valid && tag.last)));

endmodule

`default_nettype wire

//--- mvu_out_fifo.sv
// ==================================================
// Result FIFO with first-word-fall-through on the
// valid/ready output. A push into an empty FIFO is
// visible in the same cycle. room tells the walker
// that a full pipeline of results still fits.
// ==================================================
`timescale 1ns/1ps
`default_nettype none
`include "mvu_defs.svh"

module mvu_out_fifo (
    input  wire                         mvu_ext,
    input  wire                         rst_n,
    input  wire                         push,
    input  wire mvu_data_pkg::mvu_acc_t result,
    input  wire                         out_ready,
    output logic                        out_valid,
    output mvu_data_pkg::mvu_acc_t      out_data,
    output logic                        room
);
    import mvu_data_pkg::*;

    localparam int AW = $clog2(`MVU_FIFO_DEPTH);
    localparam int CW = $clog2(`MVU_FIFO_DEPTH + 1);

    mvu_acc_t      mem [`MVU_FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;   // Power-of-two depth, pointers wrap on their own
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [CW-1:0] fill;
    logic          empty;
    logic          pop;
    logic          wr;
    logic          rd;

    assign empty     = (count == '0);
    assign out_valid = !empty || push;
    assign out_data  = empty ? result : mem[rd_ptr];
    assign pop       = out_valid && out_ready;
    assign wr        = push && !(empty && out_ready);   // Bypassed word is not stored
    assign rd        = pop && !empty;

    // Entries taken once this cycle's push lands
    assign fill = count + CW'(push);
    assign room = (fill <= CW'(`MVU_FIFO_DEPTH - `MVU_PIPE_SLACK));

    always_ff @(posedge mvu_ext) begin
        if (wr) begin
            mem[wr_ptr] <= result;
        end
    end

    always_ff @(posedge mvu_ext or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + CW'(wr) - CW'(rd);
        end
    end

    a_no_overflow: assert property (@(posedge mvu_ext) disable iff (!rst_n)
        push |-> (count != CW'(`MVU_FIFO_DEPTH)));

endmodule

`default_nettype wire

//--- mvu_top.sv
// ==================================================
// Single bit-serial matrix-vector unit. Load both
// banks while idle, submit a job on the config
// channel, then take one result per row from the
// output stream. done and irq mark the job end.
// ==================================================
`timescale 1ns/1ps
`default_nettype none
`include "mvu_defs.svh"

module mvu_top (
    input  wire                         mvu_ext,
    input  wire                         rst_n,
    input  wire                         cfg_valid,
    input  wire mvu_cfg_pkg::mvu_job_t  cfg_job,
    output logic                        cfg_ready,
    input  wire mvu_data_pkg::mvu_wwr_t ww,
    input  wire mvu_data_pkg::mvu_dwr_t dw,
    output logic                        out_valid,
    output mvu_data_pkg::mvu_acc_t      out_data,
    input  wire                         out_ready,
    output logic                        busy,
    output logic                        done,
    output logic                        irq,
    input  wire                         irq_clr
);
    import mvu_data_pkg::*;
    import mvu_cfg_pkg::*;

    mvu_job_t   job;
    logic       run;
    logic       agu_last;
    logic       room;
    mvu_waddr_t waddr;
    mvu_daddr_t daddr;
    mvu_plane_t wplane;
    mvu_plane_t dplane;
    mvu_tag_t   agu_tag;
    mvu_tag_t   vvp_tag;
    mvu_acc_t   term;
    logic       push;
    mvu_acc_t   result;

    mvu_job_ctrl u_ctrl (
        .mvu_ext   (mvu_ext),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg_job   (cfg_job),
        .agu_last  (agu_last),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .irq_clr   (irq_clr),
        .cfg_ready (cfg_ready),
        .job       (job),
        .run       (run),
        .busy      (busy),
        .done      (done),
        .irq       (irq)
    );

    mvu_bank #(.BADDR(`MVU_BWADDR)) wbank (
        .mvu_ext (mvu_ext),
        .wr_en   (ww.en),
        .wr_addr (ww.addr),
        .wr_word (ww.word),
        .rd_addr (waddr),
        .rd_word (wplane)
    );

    mvu_bank #(.BADDR(`MVU_BDADDR)) dbank (
        .mvu_ext (mvu_ext),
        .wr_en   (dw.en),
        .wr_addr (dw.addr),
        .wr_word (dw.word),
        .rd_addr (daddr),
        .rd_word (dplane)
    );

    mvu_agu u_agu (
        .mvu_ext  (mvu_ext),
        .rst_n    (rst_n),
        .job      (job),
        .run      (run),
        .room     (room),
        .waddr    (waddr),
        .daddr    (daddr),
        .tag      (agu_tag),
        .agu_last (agu_last)
    );

    mvu_vvp u_vvp (
        .mvu_ext (mvu_ext),
        .rst_n   (rst_n),
        .wplane  (wplane),
        .dplane  (dplane),
        .tag_in  (agu_tag),
        .term    (term),
        .tag_out (vvp_tag)
    );

    mvu_shacc u_shacc (
        .mvu_ext (mvu_ext),
        .rst_n   (rst_n),
        .term    (term),
        .tag     (vvp_tag),
        .push    (push),
        .result  (result)
    );

    mvu_out_fifo u_fifo (
        .mvu_ext   (mvu_ext),
        .rst_n     (rst_n),
        .push      (push),
        .result    (result),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .room      (room)
    );

endmodule

`default_nettype wire

//--- tb_mvu.sv
// ==================================================
// Self-checking testbench for the MVU engine.
// Loads both banks with random planes, runs jobs
// through the config channel and checks each row
// result and the status outputs against a model
// built from the written planes.
// ==================================================
`timescale 1ns/1ps
`default_nettype none
`include "mvu_defs.svh"

module tb_mvu;
    import mvu_data_pkg::*;
    import mvu_cfg_pkg::*;

    localparam int WDEPTH     = 1 << `MVU_BWADDR;
    localparam int DDEPTH     = 1 << `MVU_BDADDR;
    localparam int MAX_CYCLES = 5 * 16 * 16 * 4 + 1000;   // Five full jobs plus bank loads

    logic       mvu_ext;
    logic       rst_n;
    logic       cfg_valid;
    mvu_job_t   cfg_job;
    logic       cfg_ready;
    mvu_wwr_t   ww;
    mvu_dwr_t   dw;
    logic       out_valid;
    mvu_acc_t   out_data;
    logic       out_ready;
    logic       busy;
    logic       done;
    logic       irq;
    logic       irq_clr;

    mvu_plane_t wref [WDEPTH];   // Copies of the written planes
    mvu_plane_t dref [DDEPTH];
    mvu_acc_t   exp_q [$];       // Row results still to come, in order
    string      test_name;
    logic       bp_en;
    int         errors;
    int         checks;
    int         result_cnt;
    int         cycles;
    logic       done_due;        // Final handshake seen on the last edge
    logic       irq_exp;
    logic       busy_exp;        // Job taken and its last result not yet accepted
    logic       stall_q;
    mvu_acc_t   data_q;

    mvu_top dut (
        .mvu_ext   (mvu_ext),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg_job   (cfg_job),
        .cfg_ready (cfg_ready),
        .ww        (ww),
        .dw        (dw),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_ready (out_ready),
        .busy      (busy),
        .done      (done),
        .irq       (irq),
        .irq_clr   (irq_clr)
    );

    initial begin
        mvu_ext = 1'b0;
        forever #2 mvu_ext = ~mvu_ext;
    end

    // Lane operand over prec bits, two's complement when signed
    function automatic int lane_value(bit from_w, int base, int prec, bit sgn, int k);
        int v;
        int a;
        v = 0;
        for (int b = 0; b < prec; b++) begin
            if (from_w) begin
                a = (base + b) % WDEPTH;
                v = v + (int'(wref[a][k]) << b);
            end else begin
                a = (base + b) % DDEPTH;
                v = v + (int'(dref[a][k]) << b);
            end
        end
        if (sgn && v >= (1 << (prec - 1))) begin
            v = v - (1 << prec);
        end
        return v;
    endfunction

    function automatic mvu_acc_t row_result(mvu_job_t j, int r);
        int sum;
        sum = 0;
        for (int k = 0; k < `MVU_N; k++) begin
            sum = sum + lane_value(1'b0, int'(j.ibase), int'(j.iprec), j.i_signed, k)
                      * lane_value(1'b1, int'(j.wbase) + r * int'(j.wprec), int'(j.wprec),
                                   j.w_signed, k);
        end
        return mvu_acc_t'(sum);   // Truncated to the result width
    endfunction

    task automatic load_banks();
        mvu_plane_t plane;
        for (int a = 0; a < WDEPTH; a++) begin
            @(posedge mvu_ext);
            plane   = mvu_plane_t'($urandom);
            wref[a] = plane;
            ww      <= '{en: 1'b1, addr: mvu_waddr_t'(a), word: plane};
            if (a < DDEPTH) begin
                plane   = mvu_plane_t'($urandom);
                dref[a] = plane;
                dw      <= '{en: 1'b1, addr: mvu_daddr_t'(a), word: plane};
            end else begin
                dw.en <= 1'b0;
            end
        end
        @(posedge mvu_ext);
        ww.en <= 1'b0;
        dw.en <= 1'b0;
    endtask

    task automatic run_job(input string name, input int iprec, input int wprec,
                           input bit i_sg, input bit w_sg, input int rows_m1, input bit stall);
        mvu_job_t j;
        int       start_cnt;
        test_name = name;
        load_banks();
        j          = '0;
        j.iprec    = mvu_prec_t'(iprec);
        j.wprec    = mvu_prec_t'(wprec);
        j.i_signed = i_sg;
        j.w_signed = w_sg;
        j.ibase    = mvu_daddr_t'($urandom);
        j.wbase    = mvu_waddr_t'($urandom);
        j.rows_m1  = mvu_rows_t'(rows_m1);
        for (int r = 0; r <= rows_m1; r++) begin
            exp_q.push_back(row_result(j, r));
        end
        start_cnt = result_cnt;
        bp_en     <= stall;
        @(posedge mvu_ext);
        cfg_valid <= 1'b1;
        cfg_job   <= j;
        do @(posedge mvu_ext); while (!cfg_ready);
        cfg_valid <= 1'b0;
        do @(posedge mvu_ext); while (!done);
        bp_en <= 1'b0;
        checks++;
        assert (result_cnt - start_cnt == rows_m1 + 1 && exp_q.size() == 0) else begin
            errors++;
            $display("FAIL %s: expected %0d results, got %0d", name, rows_m1 + 1,
                     result_cnt - start_cnt);
        end
        // irq has to survive a few idle cycles before the clear
        repeat (3) @(posedge mvu_ext);
        irq_clr <= 1'b1;
        @(posedge mvu_ext);
        irq_clr <= 1'b0;
        @(posedge mvu_ext);
    endtask

    always @(posedge mvu_ext) begin
        if (bp_en) begin
            out_ready <= 1'($urandom % 2);
        end else begin
            out_ready <= 1'b1;
        end
    end

    // Output and status monitor, sampled on the clock edge
    always @(posedge mvu_ext) begin
        mvu_acc_t exp_val;
        logic     hs;
        logic     final_hs;
        if (rst_n) begin
            hs       = out_valid && out_ready;
            final_hs = hs && (exp_q.size() == 1);
            checks   = checks + 4;
            assert (done == done_due) else begin
                errors++;
                $display("FAIL %s done: expected %0b, got %0b", test_name, done_due, done);
            end
            assert (irq == irq_exp) else begin
                errors++;
                $display("FAIL %s irq: expected %0b, got %0b", test_name, irq_exp, irq);
            end
            assert (busy === busy_exp) else begin
                errors++;
                $display("FAIL %s busy: expected %0b, got %0b", test_name, busy_exp, busy);
            end
            assert (cfg_ready === !busy_exp) else begin
                errors++;
                $display("FAIL %s cfg_ready: expected %0b, got %0b", test_name, !busy_exp,
                         cfg_ready);
            end
            if (stall_q) begin
                checks++;
                assert (out_valid && out_data === data_q) else begin
                    errors++;
                    $display("FAIL %s stalled output: expected %0d, got %0d", test_name,
                             data_q, out_data);
                end
            end
            if (hs) begin
                result_cnt++;
                checks++;
                assert (exp_q.size() > 0) else begin
                    errors++;
                    $display("Result %0d arrived with no result outstanding", out_data);
                end
                if (exp_q.size() > 0) begin
                    exp_val = exp_q.pop_front();
                    checks++;
                    assert (out_data === exp_val) else begin
                        errors++;
                        $display("FAIL %s: expected %0d, got %0d", test_name, exp_val,
                                 out_data);
                    end
                end
            end
            if (busy_exp) begin
                busy_exp = !final_hs;
            end else begin
                busy_exp = cfg_valid;
            end
            irq_exp  = final_hs || (irq_exp && !irq_clr);
            done_due = final_hs;
            stall_q  = out_valid && !out_ready;
            data_q   = out_data;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge mvu_ext);
            cycles++;
        end
        $display("Timeout, the run did not finish within %0d cycles", cycles);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(51881));
        rst_n      = 1'b0;
        cfg_valid  = 1'b0;
        cfg_job    = '0;
        ww         = '0;
        dw         = '0;
        out_ready  = 1'b0;
        irq_clr    = 1'b0;
        bp_en      = 1'b0;
        errors     = 0;
        checks     = 0;
        result_cnt = 0;
        done_due   = 1'b0;
        irq_exp    = 1'b0;
        busy_exp   = 1'b0;
        stall_q    = 1'b0;
        data_q     = '0;
        test_name  = "reset";
        repeat (4) @(posedge mvu_ext);
        rst_n <= 1'b1;
        @(posedge mvu_ext);
        checks++;
        assert (!busy && !done && !irq && !out_valid && cfg_ready) else begin
            errors++;
            $display("Status outputs are wrong after reset");
        end

        run_job("unsigned", 1 + $urandom % 4, 1 + $urandom % 4, 1'b0, 1'b0, $urandom % 16, 1'b0);
        run_job("signed_w", 3, 4, 1'b0, 1'b1, 7, 1'b0);
        run_job("signed_i", 4, 2, 1'b1, 1'b0, 9, 1'b0);
        run_job("signed_iw", 4, 4, 1'b1, 1'b1, 15, 1'b0);
        run_job("backpressure", 4, 3, 1'b1, 1'b1, 15, 1'b1);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
mvu_data_pkg.sv
mvu_cfg_pkg.sv
mvu_job_ctrl.sv
mvu_bank.sv
mvu_agu.sv
mvu_vvp.sv
mvu_shacc.sv
mvu_out_fifo.sv
mvu_top.sv
tb_mvu.sv

//--- Bender.yml
package:
  name: mvu_engine

export_include_dirs:
  - .

sources:
  - mvu_data_pkg.sv
  - mvu_cfg_pkg.sv
  - mvu_job_ctrl.sv
  - mvu_bank.sv
  - mvu_agu.sv
  - mvu_vvp.sv
  - mvu_shacc.sv
  - mvu_out_fifo.sv
  - mvu_top.sv
  - target: test
    files:
      - tb_mvu.sv
